//--- include/csr_fields.svh
`ifndef CSR_FIELDS_SVH
`define CSR_FIELDS_SVH

// CRMD
localparam int CRMD_PLV_LSB       = 0;
localparam int CRMD_PLV_W         = 2;
localparam int CRMD_IE_BIT        = 2;
localparam int CRMD_DA_BIT        = 3;

// PRMD
localparam int PRMD_PPLV_LSB      = 0;
localparam int PRMD_PPLV_W        = 2;
localparam int PRMD_PIE_BIT       = 2;

// ECFG
localparam int ECFG_LIE_LSB       = 0;
localparam int ECFG_LIE_W         = 13;

// ESTAT, IS[1:0] software, IS[9:2] hardware, IS[11] timer, IS[12] IPI
localparam int ESTAT_IS_LSB       = 0;
localparam int ESTAT_IS_W         = 13;
localparam int ESTAT_ECODE_LSB    = 16;
localparam int ESTAT_ECODE_W      = 6;
localparam int ESTAT_ESUBCODE_LSB = 22;
localparam int ESTAT_ESUBCODE_W   = 9;

// EENTRY
localparam int EENTRY_VA_LSB      = 6;
localparam int EENTRY_VA_W        = 26;

`endif

//--- hdl/csr_pkg.sv
package csr_pkg;

    `include "csr_fields.svh"

    // --------------------
    // CSR numbers
    // --------------------
    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033
    } csr_num_e;

    // Kind of instruction at writeback
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_ERTN    = 3'd4
    } csr_op_e;

    // Exception codes
    localparam logic [5:0] ECODE_INT = 6'h00;
    localparam logic [5:0] ECODE_SYS = 6'h0b;
    localparam logic [5:0] ECODE_BRK = 6'h0c;
    localparam logic [5:0] ECODE_INE = 6'h0d;

    // Hardware interrupt lines into ESTAT.IS[9:2]
    localparam int NUM_HW_INT = 8;

    // --------------------
    // Structs
    // --------------------
    typedef struct packed {
        logic       has_ex;
        logic [5:0] ecode;
        logic [8:0] esubcode;
    } wb_exc_t;

    typedef struct packed {
        csr_op_e     op;
        logic [13:0] num;
        // Mask operand of csrxchg
        logic [31:0] rj;
        logic [31:0] rd;
        logic [31:0] pc;
        wb_exc_t     exc;
    } wb_req_t;

    typedef struct packed {
        logic        we;
        logic [13:0] num;
        logic [31:0] mask;
        logic [31:0] value;
    } csr_wr_t;

    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
    } trap_t;

endpackage

//--- hdl/csr_access.sv
`timescale 1ns/1ps

module csr_access
    import csr_pkg::*;
(
    input  wb_req_t     wb_req,
    input  logic        commit,
    input  logic [31:0] rdata,
    output csr_wr_t     wr,
    output logic [31:0] rd_result
);

    logic        is_csr_op;
    logic        op_writes;
    logic [31:0] op_mask;

    // --------------------
    // Opcode decode
    // --------------------
    always_comb begin
        is_csr_op = 1'b0;
        op_writes = 1'b0;
        op_mask   = '0;
        case (wb_req.op)
            OP_CSRRD: begin
                is_csr_op = 1'b1;
            end
            OP_CSRWR: begin
                is_csr_op = 1'b1;
                op_writes = 1'b1;
                op_mask   = '1;
            end
            OP_CSRXCHG: begin
                is_csr_op = 1'b1;
                op_writes = 1'b1;
                // Only bits set in rj are replaced
                op_mask   = wb_req.rj;
            end
            default: begin
                is_csr_op = 1'b0;
                op_writes = 1'b0;
                op_mask   = '0;
            end
        endcase
    end

    // --------------------
    // Write request
    // --------------------
    always_comb begin
        // Trapped or invalid instructions leave the CSRs alone
        wr.we    = op_writes && commit;
        wr.num   = wb_req.num;
        wr.mask  = op_mask;
        wr.value = wb_req.rd;
    end

    // Old value for the rd destination
    assign rd_result = is_csr_op ? rdata : 32'h0;

endmodule

//--- hdl/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [13:0]           rd_num,
    output logic [31:0]           rdata,
    input  csr_wr_t               wr,
    input  trap_t                 trap,
    input  logic [NUM_HW_INT-1:0] hw_int,
    input  logic                  ipi_int,
    output logic [31:0]           ex_entry,
    output logic [31:0]           era,
    output logic                  int_pending
);

    // --------------------
    // Field storage
    // --------------------
    logic [CRMD_PLV_W-1:0]       crmd_plv;
    logic                        crmd_ie;
    logic [PRMD_PPLV_W-1:0]      prmd_pplv;
    logic                        prmd_pie;
    logic [ECFG_LIE_W-1:0]       ecfg_lie;
    logic [1:0]                  estat_is_sw;
    logic [NUM_HW_INT-1:0]       estat_is_hw;
    logic                        estat_is_ipi;
    logic [ESTAT_ECODE_W-1:0]    estat_ecode;
    logic [ESTAT_ESUBCODE_W-1:0] estat_esubcode;
    logic [31:0]                 era_pc;
    logic [EENTRY_VA_W-1:0]      eentry_va;
    logic [31:0]                 save_q [4];

    // Full 32-bit views of the registers
    logic [31:0]           crmd_word;
    logic [31:0]           prmd_word;
    logic [31:0]           ecfg_word;
    logic [31:0]           estat_word;
    logic [31:0]           eentry_word;
    logic [ESTAT_IS_W-1:0] estat_is;

    // Masked write results
    logic [31:0] crmd_new;
    logic [31:0] prmd_new;
    logic [31:0] ecfg_new;
    logic [31:0] estat_new;
    logic [31:0] era_new;
    logic [31:0] eentry_new;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_ecfg;
    logic wr_estat;
    logic wr_era;
    logic wr_eentry;

    function automatic logic [31:0] merge(input logic [31:0] old_val,
                                          input logic [31:0] mask,
                                          input logic [31:0] value);
        return (mask & value) | (~mask & old_val);
    endfunction

    // IS[10] reserved and IS[11] timer read zero
    assign estat_is = {estat_is_ipi, 2'b00, estat_is_hw, estat_is_sw};

    always_comb begin
        crmd_word = '0;
        crmd_word[CRMD_PLV_LSB +: CRMD_PLV_W] = crmd_plv;
        crmd_word[CRMD_IE_BIT] = crmd_ie;
        crmd_word[CRMD_DA_BIT] = 1'b1;

        prmd_word = '0;
        prmd_word[PRMD_PPLV_LSB +: PRMD_PPLV_W] = prmd_pplv;
        prmd_word[PRMD_PIE_BIT] = prmd_pie;

        ecfg_word = '0;
        ecfg_word[ECFG_LIE_LSB +: ECFG_LIE_W] = ecfg_lie;

        estat_word = '0;
        estat_word[ESTAT_IS_LSB +: ESTAT_IS_W] = estat_is;
        estat_word[ESTAT_ECODE_LSB +: ESTAT_ECODE_W] = estat_ecode;
        estat_word[ESTAT_ESUBCODE_LSB +: ESTAT_ESUBCODE_W] = estat_esubcode;

        eentry_word = '0;
        eentry_word[EENTRY_VA_LSB +: EENTRY_VA_W] = eentry_va;
    end

    assign wr_crmd   = wr.we && (wr.num == CSR_CRMD);
    assign wr_prmd   = wr.we && (wr.num == CSR_PRMD);
    assign wr_ecfg   = wr.we && (wr.num == CSR_ECFG);
    assign wr_estat  = wr.we && (wr.num == CSR_ESTAT);
    assign wr_era    = wr.we && (wr.num == CSR_ERA);
    assign wr_eentry = wr.we && (wr.num == CSR_EENTRY);

    assign crmd_new   = merge(crmd_word, wr.mask, wr.value);
    assign prmd_new   = merge(prmd_word, wr.mask, wr.value);
    assign ecfg_new   = merge(ecfg_word, wr.mask, wr.value);
    assign estat_new  = merge(estat_word, wr.mask, wr.value);
    assign era_new    = merge(era_pc, wr.mask, wr.value);
    assign eentry_new = merge(eentry_word, wr.mask, wr.value);

    // --------------------
    // Updates
    // --------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (trap.ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (trap.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_new[CRMD_PLV_LSB +: CRMD_PLV_W];
            crmd_ie  <= crmd_new[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd) begin
            prmd_pplv <= prmd_new[PRMD_PPLV_LSB +: PRMD_PPLV_W];
            prmd_pie  <= prmd_new[PRMD_PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie    <= '0;
            estat_is_sw <= '0;
        end else begin
            if (wr_ecfg) begin
                ecfg_lie <= ecfg_new[ECFG_LIE_LSB +: ECFG_LIE_W];
            end
            if (wr_estat) begin
                estat_is_sw <= estat_new[ESTAT_IS_LSB +: 2];
            end
        end
    end

    // Interrupt lines sampled every cycle
    always_ff @(posedge clk) begin
        estat_is_hw  <= hw_int;
        estat_is_ipi <= ipi_int;
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            estat_ecode    <= trap.ecode;
            estat_esubcode <= trap.esubcode;
            era_pc         <= trap.pc;
        end else if (wr_era) begin
            era_pc <= era_new;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_eentry) begin
            eentry_va <= eentry_new[EENTRY_VA_LSB +: EENTRY_VA_W];
        end
        for (int i = 0; i < 4; i++) begin
            if (wr.we && (wr.num == CSR_SAVE0 + i)) begin
                save_q[i] <= merge(save_q[i], wr.mask, wr.value);
            end
        end
    end

    // --------------------
    // Read side
    // --------------------
    always_comb begin
        case (rd_num)
            CSR_CRMD:   rdata = crmd_word;
            CSR_PRMD:   rdata = prmd_word;
            CSR_ECFG:   rdata = ecfg_word;
            CSR_ESTAT:  rdata = estat_word;
            CSR_ERA:    rdata = era_pc;
            CSR_EENTRY: rdata = eentry_word;
            CSR_SAVE0:  rdata = save_q[0];
            CSR_SAVE1:  rdata = save_q[1];
            CSR_SAVE2:  rdata = save_q[2];
            CSR_SAVE3:  rdata = save_q[3];
            default:    rdata = 32'h0;
        endcase
    end

    assign ex_entry    = eentry_word;
    assign era         = era_pc;
    assign int_pending = crmd_ie && |(estat_is & ecfg_lie);

endmodule

//--- hdl/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl
    import csr_pkg::*;
(
    input  logic        wb_valid,
    input  wb_req_t     wb_req,
    input  logic        int_pending,
    input  logic [31:0] ex_entry,
    input  logic [31:0] era,
    output trap_t       trap,
    output logic        commit,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    typedef enum logic [2:0] {
        DEC_IDLE,
        DEC_INT,
        DEC_EXC,
        DEC_ERTN,
        DEC_COMMIT
    } decision_e;

    decision_e decision;

    // --------------------
    // Priority
    // --------------------
    always_comb begin
        if (!wb_valid) begin
            decision = DEC_IDLE;
        end else if (int_pending) begin
            decision = DEC_INT;
        end else if (wb_req.exc.has_ex) begin
            decision = DEC_EXC;
        end else if (wb_req.op == OP_ERTN) begin
            decision = DEC_ERTN;
        end else begin
            decision = DEC_COMMIT;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    always_comb begin
        trap           = '0;
        trap.pc        = wb_req.pc;
        commit         = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = 32'h0;
        case (decision)
            DEC_INT: begin
                // Interrupt taken on this instruction, its pc is saved
                trap.ex        = 1'b1;
                trap.ecode     = ECODE_INT;
                trap.esubcode  = '0;
                redirect_valid = 1'b1;
                redirect_pc    = ex_entry;
            end
            DEC_EXC: begin
                trap.ex        = 1'b1;
                trap.ecode     = wb_req.exc.ecode;
                trap.esubcode  = wb_req.exc.esubcode;
                redirect_valid = 1'b1;
                redirect_pc    = ex_entry;
            end
            DEC_ERTN: begin
                trap.ertn      = 1'b1;
                redirect_valid = 1'b1;
                redirect_pc    = era;
            end
            DEC_COMMIT: begin
                commit = 1'b1;
            end
            default: begin
                commit         = 1'b0;
                redirect_valid = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  wb_valid,
    input  wb_req_t               wb_req,
    input  logic [NUM_HW_INT-1:0] hw_int,
    input  logic                  ipi_int,
    output logic [31:0]           rd_result,
    output logic                  redirect_valid,
    output logic [31:0]           redirect_pc,
    output logic                  commit
);

    csr_wr_t     wr;
    trap_t       trap;
    logic [31:0] rdata;
    logic [31:0] ex_entry;
    logic [31:0] era;
    logic        int_pending;

    csr_access u_access (
        .wb_req    (wb_req),
        .commit    (commit),
        .rdata     (rdata),
        .wr        (wr),
        .rd_result (rd_result)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .resetn      (resetn),
        .rd_num      (wb_req.num),
        .rdata       (rdata),
        .wr          (wr),
        .trap        (trap),
        .hw_int      (hw_int),
        .ipi_int     (ipi_int),
        .ex_entry    (ex_entry),
        .era         (era),
        .int_pending (int_pending)
    );

    trap_ctrl u_trap (
        .wb_valid       (wb_valid),
        .wb_req         (wb_req),
        .int_pending    (int_pending),
        .ex_entry       (ex_entry),
        .era            (era),
        .trap           (trap),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

//--- tests/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
    import csr_pkg::*;
();

    logic                  clk;
    logic                  resetn;
    logic                  wb_valid;
    wb_req_t               wb_req;
    logic [NUM_HW_INT-1:0] hw_int;
    logic                  ipi_int;
    logic [31:0]           rd_result;
    logic                  redirect_valid;
    logic [31:0]           redirect_pc;
    logic                  commit;

    integer seed = 32'hb008d8e4;
    int     checks;
    int     errors;
    int     timeouts;

    // Registers without reset come first so they are written before any read
    logic [13:0] impl_nums [10] = '{14'h001, 14'h006, 14'h00c, 14'h030, 14'h031,
                                    14'h032, 14'h033, 14'h000, 14'h004, 14'h005};
    logic [5:0]  ex_codes [3] = '{ECODE_SYS, ECODE_BRK, ECODE_INE};

    // --------------------
    // Reference model
    // --------------------
    logic [1:0]  m_plv;
    logic        m_ie;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic [12:0] m_lie;
    logic [1:0]  m_sw;
    logic [7:0]  m_hw;
    logic        m_ipi;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [25:0] m_va;
    logic [31:0] m_save [4];

    csr_unit_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] expected_csr(input logic [13:0] num);
        case (num)
            14'h000: return {28'h0, 1'b1, m_ie, m_plv};
            14'h001: return {29'h0, m_pie, m_pplv};
            14'h004: return {19'h0, m_lie};
            14'h005: return {1'b0, m_esub, m_ecode, 3'b000, m_ipi, 2'b00, m_hw, m_sw};
            14'h006: return m_era;
            14'h00c: return {m_va, 6'h00};
            14'h030, 14'h031, 14'h032, 14'h033: return m_save[num[1:0]];
            default: return 32'h0;
        endcase
    endfunction

    task automatic apply_write(input logic [13:0] num, input logic [31:0] v);
        case (num)
            14'h000: {m_ie, m_plv} = v[2:0];
            14'h001: {m_pie, m_pplv} = v[2:0];
            14'h004: m_lie = v[12:0];
            14'h005: m_sw = v[1:0];
            14'h006: m_era = v;
            14'h00c: m_va = v[31:6];
            14'h030, 14'h031, 14'h032, 14'h033: m_save[num[1:0]] = v;
            default: ;
        endcase
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic make_req(input csr_op_e op, input logic [13:0] num, output wb_req_t r);
        r     = '0;
        r.op  = op;
        r.num = num;
        r.rj  = $random(seed);
        r.rd  = $random(seed);
        r.pc  = $random(seed) & 32'hffff_fffc;
    endtask

    // Any op, any CSR number, one in four unimplemented
    task automatic random_req(output wb_req_t r);
        logic [13:0] num;
        num = ({$random(seed)} % 4 == 0) ? $random(seed) : impl_nums[{$random(seed)} % 10];
        case ({$random(seed)} % 5)
            0: make_req(OP_CSRRD, num, r);
            1: make_req(OP_CSRWR, num, r);
            2: make_req(OP_CSRXCHG, num, r);
            3: make_req(OP_ERTN, num, r);
            default: make_req(OP_NONE, num, r);
        endcase
    endtask

    // Drive one instruction, check the outputs just before the edge, advance the model
    task automatic run_cycle(input logic valid, input wb_req_t req,
                             input logic [7:0] hw, input logic ipi);
        logic [31:0] old_val;
        logic [31:0] mask;
        logic        pend;
        logic        is_csr;
        logic        exp_redir;
        @(posedge clk);
        #2;
        wb_valid = valid;
        wb_req   = req;
        hw_int   = hw;
        ipi_int  = ipi;
        #36;
        old_val   = expected_csr(req.num);
        mask      = (req.op == OP_CSRWR) ? 32'hffff_ffff : req.rj;
        pend      = m_ie && |({m_ipi, 2'b00, m_hw, m_sw} & m_lie);
        is_csr    = req.op == OP_CSRRD || req.op == OP_CSRWR || req.op == OP_CSRXCHG;
        exp_redir = valid && (pend || req.exc.has_ex || req.op == OP_ERTN);
        check(redirect_valid, exp_redir, "redirect_valid");
        check(commit, valid && !exp_redir, "commit");
        if (exp_redir) begin
            check(redirect_pc, (pend || req.exc.has_ex) ? {m_va, 6'h00} : m_era, "redirect_pc");
        end
        if (valid && is_csr) begin
            check(rd_result, old_val, "rd_result");
        end
        if (valid && (pend || req.exc.has_ex)) begin
            m_pplv  = m_plv;
            m_pie   = m_ie;
            m_plv   = 2'b00;
            m_ie    = 1'b0;
            m_ecode = pend ? ECODE_INT : req.exc.ecode;
            m_esub  = pend ? 9'h000 : req.exc.esubcode;
            m_era   = req.pc;
        end else if (exp_redir) begin
            m_plv = m_pplv;
            m_ie  = m_pie;
        end else if (valid && is_csr && req.op != OP_CSRRD) begin
            apply_write(req.num, (mask & req.rd) | (~mask & old_val));
        end
        m_hw  = hw;
        m_ipi = ipi;
    endtask

    task automatic read_back_all();
        wb_req_t req;
        foreach (impl_nums[i]) begin
            make_req(OP_CSRRD, impl_nums[i], req);
            run_cycle(1'b1, req, '0, 1'b0);
        end
    endtask

    // hw_int[0] held high until an instruction traps
    task automatic wait_for_int();
        wb_req_t req;
        int      n;
        n = 0;
        make_req(OP_CSRRD, 14'h030, req);
        run_cycle(1'b1, req, 8'h01, 1'b0);
        while (!redirect_valid && n < 16) begin
            n++;
            run_cycle(1'b1, req, 8'h01, 1'b0);
        end
        if (!redirect_valid) begin
            timeouts++;
            $display("Timeout: no interrupt was taken within 16 cycles of hw_int rising");
        end
    endtask

    task automatic report_phase(input string name);
        $display("%s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        wb_req_t req;
        int      k;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        resetn   = 1'b0;
        wb_valid = 1'b0;
        wb_req   = '0;
        hw_int   = '0;
        ipi_int  = 1'b0;
        m_plv    = 2'b00;
        m_ie     = 1'b0;
        m_lie    = '0;
        m_sw     = 2'b00;
        m_hw     = '0;
        m_ipi    = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;

        make_req(OP_CSRRD, 14'h000, req);
        run_cycle(1'b1, req, '0, 1'b0);
        check(rd_result, 32'h0000_0008, "CRMD after reset");
        make_req(OP_CSRRD, 14'h004, req);
        run_cycle(1'b1, req, '0, 1'b0);
        check(rd_result, 32'h0, "ECFG after reset");
        for (k = 0; k < 7; k++) begin
            make_req(OP_CSRWR, impl_nums[k], req);
            run_cycle(1'b1, req, '0, 1'b0);
        end
        report_phase("reset values");

        // Exceptions carry a csrwr that must not land
        for (k = 0; k < 9; k++) begin
            // Random PLV and IE for PRMD to save
            make_req(OP_CSRWR, 14'h000, req);
            run_cycle(1'b1, req, '0, 1'b0);
            make_req(OP_CSRWR, impl_nums[k % 7], req);
            req.exc.has_ex   = 1'b1;
            req.exc.ecode    = ex_codes[k % 3];
            req.exc.esubcode = $random(seed);
            run_cycle(1'b1, req, '0, 1'b0);
            read_back_all();
        end
        report_phase("exceptions");

        for (k = 0; k < 6; k++) begin
            make_req(OP_CSRWR, 14'h001, req);
            run_cycle(1'b1, req, '0, 1'b0);
            make_req(OP_ERTN, 14'h000, req);
            run_cycle(1'b1, req, '0, 1'b0);
            make_req(OP_CSRRD, 14'h000, req);
            run_cycle(1'b1, req, '0, 1'b0);
        end
        report_phase("ertn");

        for (k = 0; k < 200; k++) begin
            random_req(req);
            run_cycle(1'b1, req, '0, 1'b0);
        end
        read_back_all();
        report_phase("random access");

        make_req(OP_CSRWR, 14'h004, req);
        req.rd = 32'h0000_1fff;
        run_cycle(1'b1, req, '0, 1'b0);
        make_req(OP_CSRWR, 14'h000, req);
        req.rd = 32'h0000_0004;
        run_cycle(1'b1, req, '0, 1'b0);
        wait_for_int();
        // Re-enable now and then by writing CRMD, ECFG or ESTAT
        for (k = 0; k < 150; k++) begin
            make_req(({$random(seed)} % 2) ? OP_CSRWR : OP_CSRRD,
                     impl_nums[7 + {$random(seed)} % 3], req);
            // One in four also carries its own exception
            req.exc.has_ex   = ({$random(seed)} % 4 == 0);
            req.exc.ecode    = ex_codes[{$random(seed)} % 3];
            req.exc.esubcode = $random(seed);
            run_cycle(1'b1, req, ({$random(seed)} % 3 == 0) ? $random(seed) : 8'h00,
                      {$random(seed)} % 8 == 0);
        end
        report_phase("interrupts");

        for (k = 0; k < 30; k++) begin
            random_req(req);
            req.exc.has_ex = $random(seed);
            run_cycle(1'b0, req, '0, 1'b0);
        end
        read_back_all();
        report_phase("idle slots");

        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_regfile.sv
hdl/trap_ctrl.sv
hdl/csr_unit_top.sv
tests/csr_unit_tb.sv
